// File: core.f
common/core_pkg.sv
source/instr_decode.sv
source/alu.sv
source/register_file.sv
control/core_control.sv
source/core_top.sv
verif/core_props.sv
verif/core_tb.sv

// File: Makefile
# Verilator build for the RV32I multi-cycle core

VERILATOR  ?= verilator
FILELIST   ?= core.f
TOP        ?= core_tb
LINT_TOP   ?= core_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
SIM_ARGS   ?= +verilator+error+limit+100
PASS_TEXT  ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qxF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/core_tb.sv
// RV32I core testbench
`timescale 1ns/1ps

module core_tb;

    localparam int max_latency = 4;
    localparam logic [6:0] op_imm   = 7'h13;
    localparam logic [6:0] op_load  = 7'h03;
    localparam logic [6:0] op_jalr  = 7'h67;
    localparam logic [6:0] op_lui   = 7'h37;
    localparam logic [6:0] op_auipc = 7'h17;

    logic        clk;
    logic        rst;
    logic [31:0] mem_addr;
    logic [31:0] mem_wr_data;
    logic        mem_rd_req;
    logic        mem_wr_req;
    logic [31:0] mem_rd_data;
    logic        mem_ack;
    logic [31:0] out;
    logic        outen;
    logic        halt;

    logic [31:0] mem [1024];
    logic [31:0] expected [$];
    logic [31:0] lcg_state;
    logic [9:0]  req_index;
    int          wait_cnt = 0;
    int          prog_len = 0;
    int          out_count = 0;
    int          cycles = 0;
    int          limit;
    int          value_errors = 0;
    int          other_errors = 0;
    int          prop_failures;

    core_top #(
        .num_regs (32)
    ) core_top_i (
        .clk         (clk),
        .rst         (rst),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out         (out),
        .outen       (outen),
        .halt        (halt)
    );

    bind core_top core_props props_i (
        .clk        (clk),
        .rst        (rst),
        .mem_addr   (mem_addr),
        .mem_rd_req (mem_rd_req),
        .mem_wr_req (mem_wr_req),
        .mem_ack    (mem_ack),
        .halt       (halt)
    );

    // instruction encoders, one per RV32I format
    function automatic logic [31:0] r_format(input logic [2:0] f3, input logic [6:0] f7,
                                             input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] i_format(input logic [6:0] op, input logic [2:0] f3,
                                             input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] s_format(input int rs2, input int rs1, input int imm);
        logic [11:0] s;
        s = 12'(imm);
        return {s[11:5], 5'(rs2), 5'(rs1), 3'b010, s[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_format(input logic [2:0] f3, input int rs1,
                                             input int rs2, input int imm);
        logic [12:0] b;
        b = 13'(imm);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_format(input logic [6:0] op, input int rd, input int imm);
        return {20'(imm), 5'(rd), op};
    endfunction

    function automatic logic [31:0] j_format(input int rd, input int imm);
        logic [20:0] j;
        j = 21'(imm);
        return {j[20], j[10:1], j[11], j[19:12], 5'(rd), 7'h6f};
    endfunction

    // memory latency from a 32-bit LCG
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return 1 + int'(lcg_state[17:16]);
    endfunction

    // program words go to consecutive words from address 128
    task automatic emit(input logic [31:0] word);
        mem[32 + prog_len] = word;
        prog_len++;
    endtask

    task automatic load_program();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {16'hbad0, 16'(i)};
        end
        // x31 holds the output port address 1000000
        emit(u_format(op_lui, 31, 32'hf4));
        emit(i_format(op_imm, 3'b000, 31, 31, 32'h240));
        emit(i_format(op_imm, 3'b000, 1, 0, -7));
        emit(s_format(1, 31, 0));
        emit(i_format(op_imm, 3'b000, 2, 0, 5));
        emit(r_format(3'b010, 7'h00, 3, 1, 2));
        emit(s_format(3, 31, 0));
        emit(r_format(3'b011, 7'h00, 4, 1, 2));
        emit(s_format(4, 31, 0));
        emit(i_format(op_imm, 3'b101, 5, 1, 32'h401));
        emit(s_format(5, 31, 0));
        emit(i_format(op_imm, 3'b101, 6, 1, 28));
        emit(s_format(6, 31, 0));
        emit(r_format(3'b101, 7'h20, 7, 1, 2));
        emit(s_format(7, 31, 0));
        emit(r_format(3'b000, 7'h20, 8, 2, 1));
        emit(s_format(8, 31, 0));
        emit(i_format(op_imm, 3'b010, 9, 1, 6));
        emit(s_format(9, 31, 0));
        emit(i_format(op_imm, 3'b100, 10, 1, 32'hff));
        emit(s_format(10, 31, 0));
        emit(r_format(3'b001, 7'h00, 11, 2, 2));
        emit(s_format(11, 31, 0));
        emit(r_format(3'b111, 7'h00, 12, 10, 6));
        emit(r_format(3'b110, 7'h00, 13, 12, 11));
        emit(s_format(13, 31, 0));
        emit(u_format(op_lui, 14, 32'h12345));
        emit(s_format(14, 31, 0));
        // AUIPC sits at address 240
        emit(u_format(op_auipc, 15, 1));
        emit(s_format(15, 31, 0));
        // store then load back through data word 512
        emit(i_format(op_imm, 3'b000, 16, 0, 512));
        emit(s_format(10, 16, 0));
        emit(i_format(op_load, 3'b010, 17, 16, 0));
        emit(s_format(17, 31, 0));
        // countdown loop prints 3, 2, 1
        emit(i_format(op_imm, 3'b000, 18, 0, 3));
        emit(s_format(18, 31, 0));
        emit(i_format(op_imm, 3'b000, 18, 18, -1));
        emit(b_format(3'b001, 18, 0, -8));
        // BLT taken skips the store of x1, BGEU falls through
        emit(b_format(3'b100, 1, 2, 8));
        emit(s_format(1, 31, 0));
        emit(b_format(3'b111, 2, 1, 8));
        emit(s_format(2, 31, 0));
        emit(j_format(19, 16));
        emit(s_format(20, 31, 0));
        emit(s_format(19, 31, 0));
        emit(s_format(0, 31, 4));
        // called routine
        emit(i_format(op_imm, 3'b000, 20, 0, 77));
        emit(i_format(op_jalr, 3'b000, 0, 19, 0));
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // memory answers each request after 1 to 4 cycles
    always @(posedge clk) begin : memory_model
        int delay;
        mem_ack <= 1'b0;
        if (rst) begin
            if (wait_cnt != 0) begin
                if (wait_cnt == 1) begin
                    mem_ack     <= 1'b1;
                    mem_rd_data <= mem[req_index];
                end
                wait_cnt <= wait_cnt - 1;
            end else if (mem_rd_req || mem_wr_req) begin
                req_index <= mem_addr[11:2];
                if (mem_wr_req) begin
                    mem[mem_addr[11:2]] <= mem_wr_data;
                end
                delay = next_delay();
                if (delay == 1) begin
                    mem_ack     <= 1'b1;
                    mem_rd_data <= mem[mem_addr[11:2]];
                end else begin
                    wait_cnt <= delay - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst && outen) begin
            if (out_count < expected.size()) begin
                assert (out == expected[out_count]) else begin
                    value_errors++;
                    $display("ERROR %0d ns: output %0d is %h, expected %h",
                             $time, out_count, out, expected[out_count]);
                end
            end else begin
                other_errors++;
                $display("output %0d came after the expected list ended", out_count);
            end
            out_count++;
        end
    end

    initial begin
        rst         = 1'b0;
        mem_rd_data = '0;
        mem_ack     = 1'b0;
        lcg_state   = 32'd61;
        load_program();
        expected = '{32'hffff_fff9, 32'd1, 32'd0, 32'hffff_fffc, 32'h0000_000f,
                     32'hffff_ffff, 32'd12, 32'd1, 32'hffff_ff06, 32'h0000_00a0,
                     32'h0000_00a6, 32'h1234_5000, 32'h0000_10f0, 32'hffff_ff06,
                     32'd3, 32'd2, 32'd1, 32'd5, 32'd77, 32'd300};
        limit = 40 * prog_len * max_latency;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        while (!halt && cycles < limit) begin
            @(posedge clk);
        end
        if (!halt) begin
            other_errors++;
            $display("timeout: the core did not halt within %0d cycles", limit);
        end else begin
            // keep running so the halt checks see a quiet port
            repeat (20) @(posedge clk);
        end
        assert (out_count == expected.size()) else begin
            other_errors++;
            $display("saw %0d outputs, expected %0d", out_count, expected.size());
        end
        assert (mem[128] == 32'hffff_ff06) else begin
            value_errors++;
            $display("ERROR %0d ns: memory word 512 holds %h, expected ffffff06",
                     $time, mem[128]);
        end
        prop_failures = core_top_i.props_i.failures;
        $display("errors: %0d wrong values, %0d other, %0d assertion failures",
                 value_errors, other_errors, prop_failures);
        if (value_errors == 0 && other_errors == 0 && prop_failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verif/core_props.sv
// memory port and halt checks
`timescale 1ns/1ps

module core_props import core_pkg::*; (
    input logic  clk,
    input logic  rst,
    input addr_t mem_addr,
    input logic  mem_rd_req,
    input logic  mem_wr_req,
    input logic  mem_ack,
    input logic  halt
);

    int   failures = 0;
    logic pending;
    logic any_req;

    assign any_req = mem_rd_req || mem_wr_req;

    // a request is outstanding from its pulse until the ack
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending <= 1'b0;
        end else if (any_req) begin
            pending <= 1'b1;
        end else if (mem_ack) begin
            pending <= 1'b0;
        end
    end

    first_fetch: assert property (@(posedge clk) disable iff (!rst)
        $rose(rst) |-> mem_rd_req && !mem_wr_req && mem_addr == 32'd128)
        else begin
            failures++;
            $error("first request after reset is not a fetch at 128");
        end

    one_kind: assert property (@(posedge clk) disable iff (!rst)
        !(mem_rd_req && mem_wr_req))
        else begin
            failures++;
            $error("read and write requests raised together");
        end

    wait_for_ack: assert property (@(posedge clk) disable iff (!rst)
        pending |-> !any_req)
        else begin
            failures++;
            $error("new request issued before the ack");
        end

    // halt is a level that only reset clears
    halt_holds: assert property (@(posedge clk) disable iff (!rst)
        halt |=> halt)
        else begin
            failures++;
            $error("halt dropped before reset");
        end

    halt_quiet: assert property (@(posedge clk) disable iff (!rst)
        halt |-> !any_req)
        else begin
            failures++;
            $error("memory request while halted");
        end

endmodule

// File: source/core_top.sv
// RV32I multi-cycle core
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
    parameter int num_regs = 32
) (
    input  logic  clk,
    input  logic  rst,

    output addr_t mem_addr,
    output data_t mem_wr_data,
    output logic  mem_rd_req,
    output logic  mem_wr_req,
    input  data_t mem_rd_data,
    input  logic  mem_ack,

    output data_t out,
    output logic  outen,
    output logic  halt
);

    instr_t   instr;
    decoded_t dec;
    data_t    rs1_data;
    data_t    rs2_data;
    data_t    alu_a;
    data_t    alu_b;
    data_t    alu_result;
    logic     branch_taken;
    logic     wr_en;
    reg_sel_t wr_sel;
    data_t    wr_data;

    core_control core_control_i (
        .clk          (clk),
        .rst          (rst),
        .mem_addr     (mem_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_rd_req   (mem_rd_req),
        .mem_wr_req   (mem_wr_req),
        .mem_rd_data  (mem_rd_data),
        .mem_ack      (mem_ack),
        .out          (out),
        .outen        (outen),
        .halt         (halt),
        .instr        (instr),
        .dec          (dec),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .wr_en        (wr_en),
        .wr_sel       (wr_sel),
        .wr_data      (wr_data)
    );

    instr_decode instr_decode_i (
        .instr (instr),
        .dec   (dec)
    );

    alu alu_i (
        .op           (dec.alu_op),
        .funct3       (dec.funct3),
        .a            (alu_a),
        .b            (alu_b),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    register_file #(
        .num_regs (num_regs)
    ) register_file_i (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (dec.rs1),
        .rs2_sel  (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data)
    );

endmodule

// File: control/core_control.sv
// core control FSM
`timescale 1ns/1ps

module core_control import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    output addr_t    mem_addr,
    output data_t    mem_wr_data,
    output logic     mem_rd_req,
    output logic     mem_wr_req,
    input  data_t    mem_rd_data,
    input  logic     mem_ack,

    output data_t    out,
    output logic     outen,
    output logic     halt,

    output instr_t   instr,
    input  decoded_t dec,
    input  data_t    rs1_data,
    input  data_t    rs2_data,
    output data_t    alu_a,
    output data_t    alu_b,
    input  data_t    alu_result,
    input  logic     branch_taken,
    output logic     wr_en,
    output reg_sel_t wr_sel,
    output data_t    wr_data
);

    core_state_e state;
    core_state_e state_next;
    addr_t       pc;
    addr_t       pc_next;
    addr_t       pc_plus4;
    addr_t       branch_target;
    addr_t       jump_target;
    addr_t       fetch_pc;
    logic        issue_fetch;
    logic        instr_valid;
    logic        fetch_done;
    logic        execute;

    // EXEC waits for the fetch ack, then acts on the latched word one cycle later
    assign fetch_done = (state == EXEC) && !instr_valid && mem_ack;
    assign execute    = (state == EXEC) && instr_valid;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc + dec.imm;
    // JALR clears bit 0, JAL targets are even already
    assign jump_target   = {alu_result[31:1], 1'b0};

    always_comb begin
        case (dec.opcode)
            AUIPC, JAL: alu_a = pc;
            LUI:        alu_a = '0;
            default:    alu_a = rs1_data;
        endcase
    end

    assign alu_b = dec.use_imm ? dec.imm : rs2_data;

    always_comb begin
        state_next  = state;
        pc_next     = pc;
        fetch_pc    = pc_plus4;
        issue_fetch = 1'b0;
        mem_addr    = '0;
        mem_wr_data = '0;
        mem_rd_req  = 1'b0;
        mem_wr_req  = 1'b0;
        out         = '0;
        outen       = 1'b0;
        wr_en       = 1'b0;
        wr_sel      = dec.rd;
        wr_data     = alu_result;
        case (state)
            FETCH: begin
                fetch_pc    = pc;
                issue_fetch = 1'b1;
            end
            EXEC: begin
                if (execute) begin
                    case (dec.opcode)
                        OPIMM, OP, LUI, AUIPC: begin
                            wr_en       = 1'b1;
                            issue_fetch = 1'b1;
                        end
                        JAL, JALR: begin
                            wr_en       = 1'b1;
                            wr_data     = pc_plus4;
                            fetch_pc    = jump_target;
                            issue_fetch = 1'b1;
                        end
                        BRANCH: begin
                            fetch_pc    = branch_taken ? branch_target : pc_plus4;
                            issue_fetch = 1'b1;
                        end
                        LOAD: begin
                            mem_addr   = alu_result;
                            mem_rd_req = 1'b1;
                            pc_next    = pc_plus4;
                            state_next = MEM;
                        end
                        STORE: begin
                            if (alu_result == out_addr) begin
                                out         = rs2_data;
                                outen       = 1'b1;
                                issue_fetch = 1'b1;
                            end else if (alu_result == halt_addr) begin
                                state_next = HALTED;
                            end else begin
                                mem_addr    = alu_result;
                                mem_wr_data = rs2_data;
                                mem_wr_req  = 1'b1;
                                pc_next     = pc_plus4;
                                state_next  = MEM;
                            end
                        end
                        default: begin
                            // unknown opcode
                            state_next = HALTED;
                        end
                    endcase
                end
            end
            MEM: begin
                if (mem_ack) begin
                    wr_en      = (dec.opcode == LOAD);
                    wr_data    = mem_rd_data;
                    state_next = FETCH;
                end
            end
            default: begin
                // halted until reset, no requests
            end
        endcase

        if (issue_fetch) begin
            mem_addr   = fetch_pc;
            mem_rd_req = 1'b1;
            pc_next    = fetch_pc;
            state_next = EXEC;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= FETCH;
            pc          <= reset_pc;
            instr       <= '0;
            instr_valid <= 1'b0;
            halt        <= 1'b0;
        end else begin
            state <= state_next;
            pc    <= pc_next;
            halt  <= (state_next == HALTED);
            if (fetch_done) begin
                instr       <= mem_rd_data;
                instr_valid <= 1'b1;
            end else if (execute) begin
                instr_valid <= 1'b0;
            end
        end
    end

endmodule

// File: source/register_file.sv
// integer register file
`timescale 1ns/1ps

module register_file import core_pkg::*; #(
    parameter int num_regs = 32
) (
    input  logic     clk,
    input  logic     rst,
    input  reg_sel_t rs1_sel,
    input  reg_sel_t rs2_sel,
    output data_t    rs1_data,
    output data_t    rs2_data,
    input  logic     wr_en,
    input  reg_sel_t wr_sel,
    input  data_t    wr_data
);

    data_t regs [num_regs];

    // x0 is cleared by reset and never written, so reads need no special case
    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

endmodule

// File: source/alu.sv
// integer ALU
`timescale 1ns/1ps

module alu import core_pkg::*; (
    input  alu_op_e    op,
    input  logic [2:0] funct3,
    input  data_t      a,
    input  data_t      b,
    output data_t      result,
    output logic       branch_taken
);

    logic [4:0] shamt;
    logic       equal;

    // only the low five bits shift, for both register and immediate forms
    assign shamt = b[4:0];
    assign equal = (a == b);

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {31'b0, $signed(a) < $signed(b)};
            SLTU:    result = {31'b0, a < b};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = data_t'($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = a + b;
        endcase
    end

    // funct3 bit 0 inverts the condition: BNE, BGE and BGEU
    always_comb begin
        case (funct3[2:1])
            2'b00: begin
                branch_taken = equal ^ funct3[0];
            end
            2'b10, 2'b11: begin
                // decode picked SLT or SLTU for these
                branch_taken = result[0] ^ funct3[0];
            end
            default: begin
                // funct3 010 and 011 are not branches
                branch_taken = 1'b0;
            end
        endcase
    end

endmodule

// File: source/instr_decode.sv
// instruction decoder
`timescale 1ns/1ps

module instr_decode import core_pkg::*; (
    input  instr_t   instr,
    output decoded_t dec
);

    data_t imm_i;
    data_t imm_s;
    data_t imm_b;
    data_t imm_u;
    data_t imm_j;

    // alt selects SUB or SRA for the shared funct3 codes
    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec.opcode  = opcode_e'(instr[6:0]);
        dec.funct3  = instr[14:12];
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.alu_op  = ADD;
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        case (opcode_e'(instr[6:0]))
            // no SUBI, so only the shift-right code looks at bit 30
            OPIMM: dec.alu_op = arith_op(instr[14:12], instr[30] && instr[14:12] == 3'b101);
            OP: begin
                dec.alu_op  = arith_op(instr[14:12], instr[30]);
                dec.use_imm = 1'b0;
            end
            STORE: dec.imm = imm_s;
            BRANCH: begin
                // compare of rs1 and rs2, the target adder lives in control
                dec.alu_op  = instr[13] ? SLTU : SLT;
                dec.use_imm = 1'b0;
                dec.imm     = imm_b;
            end
            LUI, AUIPC: dec.imm = imm_u;
            JAL: dec.imm = imm_j;
            default: begin
                // LOAD and JALR keep the I-type defaults
            end
        endcase
    end

endmodule

// File: common/core_pkg.sv
// core shared definitions
package core_pkg;

    // widths that carry a meaning
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_sel_t;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OPIMM  = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    // one instruction split into the fields the core acts on
    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        reg_sel_t   rd;
        reg_sel_t   rs1;
        reg_sel_t   rs2;
        alu_op_e    alu_op;
        // second ALU operand comes from imm instead of rs2
        logic       use_imm;
        data_t      imm;
    } decoded_t;

    // EXEC covers both the fetch wait and the execute cycle
    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALTED
    } core_state_e;

    // first fetch address after reset
    localparam addr_t reset_pc = 32'd128;

    // stores to these addresses never reach memory
    localparam addr_t out_addr  = 32'd1000000;
    localparam addr_t halt_addr = 32'd1000004;

endpackage
